// ==== compile.f ====
+incdir+tests
hdl/issue_pkg.sv
hdl/issue_dec_if.sv
hdl/issue_decoder.sv
hdl/operand_fetch.sv
hdl/operand_select.sv
hdl/issue_control.sv
hdl/issue_top.sv
tests/tb_issue.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_issue
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Result: PASSED
SOURCES   := $(wildcard hdl/*.sv tests/*.sv tests/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_issue_model.svh ====
// reference rules of the issue stage; include inside the testbench module after XLEN and ROB_IDX_LEN
`ifndef TB_ISSUE_MODEL_SVH
`define TB_ISSUE_MODEL_SVH

// station picked by the major opcode, everything unknown ends in the ROB
function automatic issue_eu_t expect_target(input logic [31:0] w);
    case (w[6:0])
        OPC_LOAD:           return EU_LOAD_BUFFER;
        OPC_STORE:          return EU_STORE_BUFFER;
        OPC_BRANCH:         return EU_BRANCH_UNIT;
        OPC_OP, OPC_OP_IMM: return EU_INT_ALU;
        default:            return EU_NONE;     // fences, SYSTEM, illegal
    endcase
endfunction

// {rs1 needed, rs2 needed, rd renamed}
function automatic logic [2:0] expect_needs(input logic [31:0] w);
    case (w[6:0])
        OPC_LOAD, OPC_OP_IMM:  return 3'b101;
        OPC_STORE, OPC_BRANCH: return 3'b110;   // no rd
        OPC_OP:                return 3'b111;
        default:               return 3'b000;
    endcase
endfunction

// {ready, value} of one source: register file, then ROB, then a clean CDB hit
function automatic logic [XLEN:0] expect_operand(
    input logic                   req, busy, rob_rdy, cdb_v, cdb_exc,
    input logic [ROB_IDX_LEN-1:0] idx, cdb_idx,
    input logic [XLEN-1:0]        rf_val, rob_val, cdb_val
);
    if (!req) begin
        return '0;
    end
    if (!busy) begin
        return {1'b1, rf_val};
    end
    if (rob_rdy) begin
        return {1'b1, rob_val};
    end
    if (cdb_v && !cdb_exc && cdb_idx == idx) begin
        return {1'b1, cdb_val};
    end
    return '0;                                  // station waits on the CDB
endfunction

// 12-bit immediate for the buffers and the branch unit, zero on the ALU path
function automatic logic [11:0] expect_imm(input logic [31:0] w);
    case (w[6:0])
        OPC_LOAD:   return w[31:20];
        OPC_STORE:  return {w[31:25], w[11:7]};
        OPC_BRANCH: return {w[31], w[7], w[30:25], w[11:8]};   // offset[12:1]
        default:    return 12'd0;
    endcase
endfunction

// ALU operand B; OP-IMM replaces rs2 with a shift amount or a sign extended imm
function automatic logic [XLEN-1:0] expect_alu_b(input logic [31:0] w, input logic [XLEN-1:0] rs2);
    if (w[6:0] == OPC_OP) begin
        return rs2;
    end
    if (w[14:12] == 3'b001 || w[14:12] == 3'b101) begin
        return {{(XLEN-6){1'b0}}, w[25:20]};
    end
    return {{(XLEN-12){w[31]}}, w[31:20]};
endfunction

// {raised, code}, fetch exceptions first
function automatic logic [4:0] expect_except(
    input logic [31:0] w,
    input logic        iq_exc,
    input logic [3:0]  iq_code
);
    logic       dec_exc;
    logic [3:0] dec_code;
    dec_exc  = !(w[6:0] inside {OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_OP, OPC_OP_IMM, OPC_MISC_MEM});
    dec_code = EXC_ILLEGAL_INSTR;
    if (w[6:0] == OPC_SYSTEM && w[14:12] == 3'b000 && w[31:20] == 12'd0) begin
        dec_code = EXC_ECALL_M;
    end else if (w[6:0] == OPC_SYSTEM && w[14:12] == 3'b000 && w[31:20] == 12'd1) begin
        dec_code = EXC_BREAKPOINT;
    end
    if (iq_exc) begin
        return {1'b1, iq_code};
    end
    return {dec_exc, dec_code};
endfunction

`endif

// ==== tests/tb_issue.sv ====
// random trials at default parameters; the DUT is combinational, reset only gates the start
module tb_issue import issue_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          XLEN          = 64;
    localparam int          ROB_IDX_LEN   = 4;
    localparam int          CLK_PERIOD    = 20;
    localparam int          N_TRIALS      = 2000;
    localparam int          RESET_TIMEOUT = 20;   // cycles
    localparam logic [31:0] SEED          = 32'h993e_61c4;

    `include "tb_issue_model.svh"

    logic clk = 1'b0;
    logic rst_n;
    int   errors;
    int   checks;
    logic [31:0] lfsr_state;

    logic                   iq_valid_i, iq_ready_o, iq_except_raised_i;
    logic [XLEN-1:0]        iq_pc_i;
    instr_t                 iq_instr_i;
    except_code_t           iq_except_code_i;
    logic                   regstat_ready_i, regstat_valid_o;
    logic                   regstat_rs1_busy_i, regstat_rs2_busy_i;
    logic [ROB_IDX_LEN-1:0] regstat_rs1_rob_idx_i, regstat_rs2_rob_idx_i;
    logic [REG_IDX_LEN-1:0] rs1_idx_o, rs2_idx_o, rd_idx_o;
    logic [XLEN-1:0]        rf_rs1_value_i, rf_rs2_value_i;
    logic                   cdb_valid_i, cdb_except_raised_i;
    logic [XLEN-1:0]        cdb_value_i;
    logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i;
    logic                   rob_ready_i, rob_rs1_ready_i, rob_rs2_ready_i;
    logic [XLEN-1:0]        rob_rs1_value_i, rob_rs2_value_i;
    logic [ROB_IDX_LEN-1:0] rob_tail_idx_i, rob_rs1_idx_o, rob_rs2_idx_o, ex_rob_idx_o;
    logic                   rob_valid_o, rob_except_raised_o, rob_res_ready_o;
    instr_t                 rob_instr_o;
    except_code_t           rob_except_code_o;
    logic [XLEN-1:0]        rob_except_aux_o;
    logic [EU_N-1:0]        ex_ready_i, ex_valid_o;
    logic                   ex_rs1_ready_o, ex_rs2_ready_o, stall_o;
    logic [XLEN-1:0]        ex_rs1_value_o, ex_rs2_value_o;
    logic [I_IMM-1:0]       ex_imm_o;

    issue_top #(.XLEN(XLEN), .ROB_IDX_LEN(ROB_IDX_LEN)) dut (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};   // one step per bit
        end
        return v;
    endfunction

    function automatic logic mostly_high();
        return take_bits(2) != 64'd0;     // 3 out of 4
    endfunction

    function automatic logic [31:0] make_instr();
        logic [3:0]  kind;
        logic [24:0] body;
        logic        brk;
        kind = 4'(take_bits(4));
        body = 25'(take_bits(25));
        brk  = 1'(take_bits(1));
        case (kind)
            4'd0, 4'd1: return {body, OPC_LOAD};
            4'd2, 4'd3: return {body, OPC_STORE};
            4'd4, 4'd5: return {body, OPC_BRANCH};
            4'd6, 4'd7: return {body, OPC_OP_IMM};
            4'd8, 4'd9: return {body, OPC_OP};
            4'd10:      return {body, OPC_MISC_MEM};
            4'd11:      return {body, OPC_SYSTEM};        // mostly CSR, so illegal
            4'd12:      return {11'd0, brk, body[12:8], 3'b000, body[4:0], OPC_SYSTEM};
            default:    return 32'(take_bits(32));        // any word
        endcase
    endfunction

    task automatic idle_inputs();
        iq_valid_i = 1'b0;
        iq_pc_i = '0;
        iq_instr_i = '0;
        iq_except_raised_i = 1'b0;
        iq_except_code_i = EXC_ILLEGAL_INSTR;
        regstat_ready_i = 1'b0;
        {regstat_rs1_busy_i, regstat_rs2_busy_i} = 2'b00;
        {regstat_rs1_rob_idx_i, regstat_rs2_rob_idx_i} = '0;
        {rf_rs1_value_i, rf_rs2_value_i} = '0;
        {cdb_valid_i, cdb_except_raised_i} = 2'b00;
        cdb_value_i = '0;
        cdb_rob_idx_i = '0;
        {rob_ready_i, rob_rs1_ready_i, rob_rs2_ready_i} = 3'b000;
        {rob_rs1_value_i, rob_rs2_value_i} = '0;
        rob_tail_idx_i = '0;
        ex_ready_i = '0;
    endtask

    task automatic drive_inputs();
        logic [1:0] pick;
        iq_instr_i         = instr_t'(make_instr());
        iq_valid_i         = mostly_high();
        iq_pc_i            = take_bits(XLEN);
        iq_except_raised_i = (take_bits(3) == 64'd0);
        pick               = 2'(take_bits(2));
        iq_except_code_i   = (pick == 2'd0) ? EXC_ILLEGAL_INSTR :
                             (pick == 2'd1) ? EXC_BREAKPOINT : EXC_ECALL_M;
        rob_ready_i        = mostly_high();
        regstat_ready_i    = mostly_high();
        for (int i = 0; i < EU_N; i++) begin
            ex_ready_i[i] = mostly_high();
        end
        regstat_rs1_busy_i    = 1'(take_bits(1));
        regstat_rs2_busy_i    = 1'(take_bits(1));
        regstat_rs1_rob_idx_i = ROB_IDX_LEN'(take_bits(ROB_IDX_LEN));
        regstat_rs2_rob_idx_i = ROB_IDX_LEN'(take_bits(ROB_IDX_LEN));
        rob_rs1_ready_i       = (take_bits(2) == 64'd0);   // rare, so the CDB gets used
        rob_rs2_ready_i       = (take_bits(2) == 64'd0);
        cdb_valid_i           = mostly_high();
        cdb_except_raised_i   = (take_bits(2) == 64'd0);
        pick                  = 2'(take_bits(2));
        cdb_rob_idx_i         = (pick == 2'd0) ? regstat_rs1_rob_idx_i :
                                (pick == 2'd1) ? regstat_rs2_rob_idx_i :
                                ROB_IDX_LEN'(take_bits(ROB_IDX_LEN));
        rf_rs1_value_i  = take_bits(XLEN);
        rf_rs2_value_i  = take_bits(XLEN);
        rob_rs1_value_i = take_bits(XLEN);
        rob_rs2_value_i = take_bits(XLEN);
        cdb_value_i     = take_bits(XLEN);
        rob_tail_idx_i  = ROB_IDX_LEN'(take_bits(ROB_IDX_LEN));
    endtask

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_outputs();
        logic [31:0]     w;
        issue_eu_t       eu;
        logic [2:0]      needs;
        logic [XLEN:0]   op1, op2;
        logic [4:0]      exc;
        logic [EU_N-1:0] onehot;
        logic            fire;
        logic [XLEN-1:0] exp_rs2;
        logic            imm_for_rs2;   // immediate stands in for rs2
        w     = iq_instr_i;
        eu    = expect_target(w);
        needs = expect_needs(w);
        op1   = expect_operand(needs[2], regstat_rs1_busy_i, rob_rs1_ready_i, cdb_valid_i,
                    cdb_except_raised_i, regstat_rs1_rob_idx_i, cdb_rob_idx_i,
                    rf_rs1_value_i, rob_rs1_value_i, cdb_value_i);
        op2   = expect_operand(needs[1], regstat_rs2_busy_i, rob_rs2_ready_i, cdb_valid_i,
                    cdb_except_raised_i, regstat_rs2_rob_idx_i, cdb_rob_idx_i,
                    rf_rs2_value_i, rob_rs2_value_i, cdb_value_i);
        exc         = expect_except(w, iq_except_raised_i, iq_except_code_i);
        onehot      = (eu == EU_NONE) ? '0 : (EU_N'(1) << eu);
        fire        = iq_valid_i && rob_ready_i && regstat_ready_i &&
                      (eu == EU_NONE || (onehot & ex_ready_i) != '0);
        imm_for_rs2 = (w[6:0] == OPC_LOAD) || (w[6:0] == OPC_OP_IMM);
        case (eu)
            EU_STORE_BUFFER, EU_BRANCH_UNIT: exp_rs2 = op2[XLEN-1:0];
            EU_INT_ALU:                      exp_rs2 = expect_alu_b(w, op2[XLEN-1:0]);
            default:                         exp_rs2 = '0;
        endcase
        check_value("iq_ready_o", 64'(iq_ready_o), 64'(fire));
        check_value("rob_valid_o", 64'(rob_valid_o), 64'(fire));
        check_value("ex_valid_o", 64'(ex_valid_o), 64'(fire ? onehot : '0));
        check_value("regstat_valid_o", 64'(regstat_valid_o), 64'(fire && needs[0]));
        check_value("ex_rs1_ready_o", 64'(ex_rs1_ready_o), 64'(op1[XLEN]));
        check_value("ex_rs1_value_o", ex_rs1_value_o, (eu == EU_NONE) ? '0 : op1[XLEN-1:0]);
        check_value("ex_rs2_ready_o", 64'(ex_rs2_ready_o), 64'(op2[XLEN] || imm_for_rs2));
        check_value("ex_rs2_value_o", ex_rs2_value_o, exp_rs2);
        check_value("ex_imm_o", 64'(ex_imm_o), 64'(expect_imm(w)));
        check_value("rob_except_raised_o", 64'(rob_except_raised_o), 64'(exc[4]));
        if (exc[4]) begin
            check_value("rob_except_code_o", 64'(rob_except_code_o), 64'(exc[3:0]));
        end
        check_value("rob_except_aux_o", rob_except_aux_o, iq_pc_i);
        check_value("rob_res_ready_o", 64'(rob_res_ready_o), 64'(w[6:0] == OPC_MISC_MEM));
        check_value("stall_o", 64'(stall_o), 64'(exc[4] || eu == EU_NONE));
        check_value("rs1_idx_o", 64'(rs1_idx_o), 64'(w[19:15]));
        check_value("rs2_idx_o", 64'(rs2_idx_o), 64'(w[24:20]));
        check_value("rd_idx_o", 64'(rd_idx_o), 64'(w[11:7]));
        check_value("rob_rs1_idx_o", 64'(rob_rs1_idx_o), 64'(regstat_rs1_rob_idx_i));
        check_value("rob_rs2_idx_o", 64'(rob_rs2_idx_o), 64'(regstat_rs2_rob_idx_i));
        check_value("rob_instr_o", 64'(rob_instr_o), 64'(w));
        check_value("ex_rob_idx_o", 64'(ex_rob_idx_o), 64'(rob_tail_idx_i));
    endtask

    initial begin
        int wait_cycles;
        lfsr_state  = SEED;
        errors      = 0;
        checks      = 0;
        wait_cycles = 0;
        idle_inputs();
        while (rst_n !== 1'b1 && wait_cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
        end else begin
            @(posedge clk);
            check_outputs();                        // idle queue, nothing may issue
            for (int t = 0; t < N_TRIALS; t++) begin
                @(negedge clk);
                drive_inputs();
                @(posedge clk);
                check_outputs();
            end
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/issue_top.sv ====
// combinational issue stage; rs2 reports ready when operand B is an immediate (load, OP-IMM)
module issue_top import issue_pkg::*; #(
    parameter int XLEN        = 64,
    parameter int ROB_IDX_LEN = 4
) (
    // issue queue
    input  logic                   iq_valid_i,
    output logic                   iq_ready_o,
    input  logic [XLEN-1:0]        iq_pc_i,
    input  instr_t                 iq_instr_i,
    input  logic                   iq_except_raised_i,
    input  except_code_t           iq_except_code_i,
    // register status table
    input  logic                   regstat_ready_i,
    output logic                   regstat_valid_o,
    input  logic                   regstat_rs1_busy_i,
    input  logic [ROB_IDX_LEN-1:0] regstat_rs1_rob_idx_i,
    input  logic                   regstat_rs2_busy_i,
    input  logic [ROB_IDX_LEN-1:0] regstat_rs2_rob_idx_i,
    // source/dest indices, shared by regstat and register file
    output logic [REG_IDX_LEN-1:0] rs1_idx_o,
    output logic [REG_IDX_LEN-1:0] rs2_idx_o,
    output logic [REG_IDX_LEN-1:0] rd_idx_o,
    // register file
    input  logic [XLEN-1:0]        rf_rs1_value_i,
    input  logic [XLEN-1:0]        rf_rs2_value_i,
    // CDB
    input  logic                   cdb_valid_i,
    input  logic                   cdb_except_raised_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    // ROB
    input  logic                   rob_ready_i,
    input  logic                   rob_rs1_ready_i,
    input  logic [XLEN-1:0]        rob_rs1_value_i,
    input  logic                   rob_rs2_ready_i,
    input  logic [XLEN-1:0]        rob_rs2_value_i,
    input  logic [ROB_IDX_LEN-1:0] rob_tail_idx_i,
    output logic                   rob_valid_o,
    output logic [ROB_IDX_LEN-1:0] rob_rs1_idx_o,
    output logic [ROB_IDX_LEN-1:0] rob_rs2_idx_o,
    output instr_t                 rob_instr_o,
    output logic                   rob_except_raised_o,
    output except_code_t           rob_except_code_o,
    output logic [XLEN-1:0]        rob_except_aux_o,
    output logic                   rob_res_ready_o,
    // reservation stations
    input  logic [EU_N-1:0]        ex_ready_i,
    output logic [EU_N-1:0]        ex_valid_o,
    output logic                   ex_rs1_ready_o,
    output logic [XLEN-1:0]        ex_rs1_value_o,
    output logic                   ex_rs2_ready_o,
    output logic [XLEN-1:0]        ex_rs2_value_o,
    output logic [I_IMM-1:0]       ex_imm_o,
    output logic [ROB_IDX_LEN-1:0] ex_rob_idx_o,
    // to the main control
    output logic                   stall_o
);

    logic            rs1_ready, rs2_ready;
    logic [XLEN-1:0] rs1_value, rs2_value;

    issue_dec_if dec_if ();

    assign rs1_idx_o     = iq_instr_i.r_view.rs1;
    assign rs2_idx_o     = iq_instr_i.r_view.rs2;
    assign rd_idx_o      = iq_instr_i.r_view.rd;
    assign rob_rs1_idx_o = regstat_rs1_rob_idx_i;   // ROB lookup of the producers
    assign rob_rs2_idx_o = regstat_rs2_rob_idx_i;
    assign rob_instr_o   = iq_instr_i;
    assign ex_rob_idx_o  = rob_tail_idx_i;          // entry allocated to this instr

    issue_decoder u_decoder (
        .instr_i (iq_instr_i),
        .dec     (dec_if.dec)
    );

    operand_fetch #(.XLEN(XLEN), .ROB_IDX_LEN(ROB_IDX_LEN)) u_fetch_rs1 (
        .req_i               (dec_if.rs1_req),
        .busy_i              (regstat_rs1_busy_i),
        .rob_idx_i           (regstat_rs1_rob_idx_i),
        .rf_value_i          (rf_rs1_value_i),
        .rob_ready_i         (rob_rs1_ready_i),
        .rob_value_i         (rob_rs1_value_i),
        .cdb_valid_i         (cdb_valid_i),
        .cdb_except_raised_i (cdb_except_raised_i),
        .cdb_rob_idx_i       (cdb_rob_idx_i),
        .cdb_value_i         (cdb_value_i),
        .ready_o             (rs1_ready),
        .value_o             (rs1_value)
    );

    operand_fetch #(.XLEN(XLEN), .ROB_IDX_LEN(ROB_IDX_LEN)) u_fetch_rs2 (
        .req_i               (dec_if.rs2_req),
        .busy_i              (regstat_rs2_busy_i),
        .rob_idx_i           (regstat_rs2_rob_idx_i),
        .rf_value_i          (rf_rs2_value_i),
        .rob_ready_i         (rob_rs2_ready_i),
        .rob_value_i         (rob_rs2_value_i),
        .cdb_valid_i         (cdb_valid_i),
        .cdb_except_raised_i (cdb_except_raised_i),
        .cdb_rob_idx_i       (cdb_rob_idx_i),
        .cdb_value_i         (cdb_value_i),
        .ready_o             (rs2_ready),
        .value_o             (rs2_value)
    );

    assign ex_rs1_ready_o = rs1_ready;
    // imm in place of rs2 is known at issue
    assign ex_rs2_ready_o = rs2_ready || (dec_if.imm_req && !dec_if.rs2_req);

    operand_select #(.XLEN(XLEN)) u_operand_select (
        .instr_i        (iq_instr_i),
        .dec            (dec_if.sink),
        .rs1_value_i    (rs1_value),
        .rs2_value_i    (rs2_value),
        .ex_rs1_value_o (ex_rs1_value_o),
        .ex_rs2_value_o (ex_rs2_value_o),
        .ex_imm_o       (ex_imm_o)
    );

    issue_control #(.XLEN(XLEN)) u_issue_control (
        .dec                (dec_if.sink),
        .iq_valid_i         (iq_valid_i),
        .iq_pc_i            (iq_pc_i),
        .iq_except_raised_i (iq_except_raised_i),
        .iq_except_code_i   (iq_except_code_i),
        .rob_ready_i        (rob_ready_i),
        .regstat_ready_i    (regstat_ready_i),
        .ex_ready_i         (ex_ready_i),
        .iq_ready_o         (iq_ready_o),
        .rob_valid_o        (rob_valid_o),
        .ex_valid_o         (ex_valid_o),
        .regstat_valid_o    (regstat_valid_o),
        .except_raised_o    (rob_except_raised_o),
        .except_code_o      (rob_except_code_o),
        .except_aux_o       (rob_except_aux_o),
        .res_ready_o        (rob_res_ready_o),
        .stall_o            (stall_o)
    );

endmodule

// ==== hdl/issue_control.sv ====
// issue handshake is all levels; a fetch exception hides any decode exception of the same instr
module issue_control import issue_pkg::*; #(
    parameter int XLEN = 64
) (
    issue_dec_if.sink       dec,
    input  logic            iq_valid_i,
    input  logic [XLEN-1:0] iq_pc_i,
    input  logic            iq_except_raised_i,
    input  except_code_t    iq_except_code_i,
    input  logic            rob_ready_i,
    input  logic            regstat_ready_i,
    input  logic [EU_N-1:0] ex_ready_i,
    output logic            iq_ready_o,
    output logic            rob_valid_o,
    output logic [EU_N-1:0] ex_valid_o,
    output logic            regstat_valid_o,
    output logic            except_raised_o,
    output except_code_t    except_code_o,
    output logic [XLEN-1:0] except_aux_o,
    output logic            res_ready_o,
    output logic            stall_o
);

    logic [EU_N-1:0] eu_sel;        // one-hot station, zero for EU_NONE
    logic            station_ok;
    logic            fire;

    always_comb begin
        eu_sel = '0;
        if (dec.eu < EU_N) begin
            eu_sel[dec.eu[$clog2(EU_N)-1:0]] = 1'b1;
        end
    end

    // EU_NONE has no station to wait on
    assign station_ok = (dec.eu == EU_NONE) || ((eu_sel & ex_ready_i) != '0);
    assign fire       = iq_valid_i && rob_ready_i && regstat_ready_i && station_ok;

    assign iq_ready_o      = fire;                      // pop the queue head
    assign rob_valid_o     = fire;
    assign ex_valid_o      = fire ? eu_sel : '0;
    assign regstat_valid_o = fire && dec.regstat_upd;   // rename rd only on issue

    always_comb begin
        if (iq_except_raised_i) begin
            except_raised_o = 1'b1;
            except_code_o   = iq_except_code_i;         // fetch side wins
        end else if (dec.except_raised) begin
            except_raised_o = 1'b1;
            except_code_o   = dec.except_code;
        end else begin
            except_raised_o = 1'b0;
            except_code_o   = iq_except_code_i;         // don't care without raised
        end
    end

    assign except_aux_o = iq_pc_i;                      // faulting PC
    assign res_ready_o  = dec.res_ready;
    assign stall_o      = except_raised_o || dec.stall_possible;

endmodule

// ==== hdl/operand_select.sv ====
// builds station operands; branch imm is offset[12:1], shift amounts are log2(XLEN) bits
module operand_select import issue_pkg::*; #(
    parameter int XLEN = 64
) (
    input  instr_t           instr_i,
    issue_dec_if.sink        dec,
    input  logic [XLEN-1:0]  rs1_value_i,
    input  logic [XLEN-1:0]  rs2_value_i,
    output logic [XLEN-1:0]  ex_rs1_value_o,
    output logic [XLEN-1:0]  ex_rs2_value_o,
    output logic [I_IMM-1:0] ex_imm_o
);

    localparam int SHAMT_W = $clog2(XLEN);

    logic [I_IMM-1:0] imm_i, imm_s, imm_b;
    logic [XLEN-1:0]  alu_b;    // second ALU operand

    assign imm_i = {instr_i.r_view.funct7, instr_i.r_view.rs2};
    assign imm_s = {instr_i.s_view.imm_hi, instr_i.s_view.imm_lo};
    // B offset bits 12..1, bit 0 is always zero
    assign imm_b = {instr_i.s_view.imm_hi[6], instr_i.s_view.imm_lo[0],
                    instr_i.s_view.imm_hi[5:0], instr_i.s_view.imm_lo[4:1]};

    always_comb begin
        if (!dec.imm_req) begin
            alu_b = rs2_value_i;
        end else if (dec.imm_format == IMM_SHAMT) begin
            alu_b = {{(XLEN-SHAMT_W){1'b0}}, imm_i[SHAMT_W-1:0]};   // zero extended
        end else begin
            alu_b = {{(XLEN-I_IMM){imm_i[I_IMM-1]}}, imm_i};        // sign extended
        end
    end

    always_comb begin
        ex_rs1_value_o = '0;
        ex_rs2_value_o = '0;
        ex_imm_o       = '0;
        case (dec.eu)
            EU_LOAD_BUFFER: begin
                ex_rs1_value_o = rs1_value_i;
                ex_imm_o       = imm_i;
            end
            EU_STORE_BUFFER: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = rs2_value_i;
                ex_imm_o       = imm_s;
            end
            EU_BRANCH_UNIT: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = rs2_value_i;
                ex_imm_o       = imm_b;
            end
            EU_INT_ALU: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = alu_b;                 // imm already folded in
            end
            default: ;                                  // EU_NONE keeps zeros
        endcase
    end

endmodule

// ==== hdl/operand_fetch.sv ====
// one source operand; the CDB is only taken when valid and free of exceptions
module operand_fetch #(
    parameter int XLEN        = 64,
    parameter int ROB_IDX_LEN = 4
) (
    input  logic                   req_i,               // operand needed by the instr
    input  logic                   busy_i,              // regstat: in flight
    input  logic [ROB_IDX_LEN-1:0] rob_idx_i,           // regstat: producer entry
    input  logic [XLEN-1:0]        rf_value_i,
    input  logic                   rob_ready_i,         // producer result already in ROB
    input  logic [XLEN-1:0]        rob_value_i,
    input  logic                   cdb_valid_i,
    input  logic                   cdb_except_raised_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    input  logic [XLEN-1:0]        cdb_value_i,
    output logic                   ready_o,
    output logic [XLEN-1:0]        value_o
);

    logic cdb_hit;  // producer is broadcasting right now

    assign cdb_hit = cdb_valid_i && !cdb_except_raised_i && (cdb_rob_idx_i == rob_idx_i);

    always_comb begin
        ready_o = 1'b0;
        value_o = '0;
        if (req_i) begin
            if (!busy_i) begin
                ready_o = 1'b1;
                value_o = rf_value_i;               // committed value
            end else if (rob_ready_i) begin
                ready_o = 1'b1;
                value_o = rob_value_i;
            end else if (cdb_hit) begin
                ready_o = 1'b1;
                value_o = cdb_value_i;
            end
            // otherwise the station snoops the CDB later
        end
    end

endmodule

// ==== hdl/issue_decoder.sv ====
// decode is by opcode only; CSR accesses and any SYSTEM word other than ecall/ebreak are illegal
module issue_decoder import issue_pkg::*; (
    input  instr_t          instr_i,
    issue_dec_if.dec        dec
);

    logic [11:0] sys_funct12;   // imm field of SYSTEM, 0 = ecall, 1 = ebreak
    logic        sys_base;      // funct3 == PRIV

    assign sys_funct12 = {instr_i.r_view.funct7, instr_i.r_view.rs2};
    assign sys_base    = (instr_i.r_view.funct3 == 3'b000);

    always_comb begin
        // defaults describe an instr that goes straight to the ROB
        dec.eu             = EU_NONE;
        dec.rs1_req        = 1'b0;
        dec.rs2_req        = 1'b0;
        dec.imm_req        = 1'b0;
        dec.imm_format     = IMM_I;
        dec.regstat_upd    = 1'b0;
        dec.except_raised  = 1'b0;
        dec.except_code    = EXC_ILLEGAL_INSTR;
        dec.res_ready      = 1'b0;
        dec.stall_possible = 1'b0;

        case (instr_i.r_view.opcode)
            OPC_LOAD: begin
                dec.eu          = EU_LOAD_BUFFER;
                dec.rs1_req     = 1'b1;                 // base address
                dec.imm_req     = 1'b1;
                dec.regstat_upd = 1'b1;
            end
            OPC_STORE: begin
                dec.eu         = EU_STORE_BUFFER;
                dec.rs1_req    = 1'b1;
                dec.rs2_req    = 1'b1;                  // store data
                dec.imm_req    = 1'b1;
                dec.imm_format = IMM_S;
            end
            OPC_BRANCH: begin
                dec.eu         = EU_BRANCH_UNIT;
                dec.rs1_req    = 1'b1;
                dec.rs2_req    = 1'b1;
                dec.imm_req    = 1'b1;
                dec.imm_format = IMM_B;
            end
            OPC_OP: begin
                dec.eu          = EU_INT_ALU;
                dec.rs1_req     = 1'b1;
                dec.rs2_req     = 1'b1;
                dec.regstat_upd = 1'b1;
            end
            OPC_OP_IMM: begin
                dec.eu          = EU_INT_ALU;
                dec.rs1_req     = 1'b1;
                dec.imm_req     = 1'b1;
                dec.regstat_upd = 1'b1;
                // slli / srli / srai take a shift amount, not a full imm
                if (instr_i.r_view.funct3 == 3'b001 || instr_i.r_view.funct3 == 3'b101) begin
                    dec.imm_format = IMM_SHAMT;
                end
            end
            OPC_MISC_MEM: begin
                // fences drain the pipeline, nothing to execute
                dec.res_ready      = 1'b1;
                dec.stall_possible = 1'b1;
            end
            OPC_SYSTEM: begin
                dec.except_raised  = 1'b1;
                dec.stall_possible = 1'b1;
                if (sys_base && sys_funct12 == 12'd0) begin
                    dec.except_code = EXC_ECALL_M;
                end else if (sys_base && sys_funct12 == 12'd1) begin
                    dec.except_code = EXC_BREAKPOINT;
                end
            end
            default: begin
                dec.except_raised  = 1'b1;              // unknown opcode
                dec.stall_possible = 1'b1;
            end
        endcase
    end

endmodule

// ==== hdl/issue_dec_if.sv ====
// decoded control bundle of the instruction at the queue head, combinational only
interface issue_dec_if import issue_pkg::*; ();

    issue_eu_t    eu;               // assigned station
    logic         rs1_req;
    logic         rs2_req;
    logic         imm_req;
    imm_format_t  imm_format;
    logic         regstat_upd;      // instr writes rd
    logic         except_raised;    // decode-time exception
    except_code_t except_code;
    logic         res_ready;        // ROB entry ready to commit at once
    logic         stall_possible;

    modport dec (
        output eu, rs1_req, rs2_req, imm_req, imm_format, regstat_upd,
        output except_raised, except_code, res_ready, stall_possible
    );

    modport sink (
        input eu, rs1_req, rs2_req, imm_req, imm_format, regstat_upd,
        input except_raised, except_code, res_ready, stall_possible
    );

endinterface

// ==== hdl/issue_pkg.sv ====
// integer-only RV64 issue types; the fetch side must send codes from except_code_t only
package issue_pkg;

    localparam int ILEN        = 32;    // instruction width
    localparam int REG_IDX_LEN = 5;     // architectural register index
    localparam int EU_N        = 4;     // stations with a valid/ready pair
    localparam int I_IMM       = 12;    // width of the immediate sent to the stations

    // register view of the word (R/I formats)
    typedef struct packed {
        logic [6:0]             funct7;
        logic [REG_IDX_LEN-1:0] rs2;     // low part of the I immediate
        logic [REG_IDX_LEN-1:0] rs1;
        logic [2:0]             funct3;
        logic [REG_IDX_LEN-1:0] rd;
        logic [6:0]             opcode;
    } instr_r_t;

    // split immediate view, shared by the S and B formats
    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [REG_IDX_LEN-1:0] rs2;
        logic [REG_IDX_LEN-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } instr_s_t;

    typedef union packed {
        instr_r_t r_view;
        instr_s_t s_view;
    } instr_t;

    // bit order of ex_valid_o / ex_ready_i follows these values
    typedef enum logic [2:0] {
        EU_LOAD_BUFFER  = 3'd0,
        EU_STORE_BUFFER = 3'd1,
        EU_BRANCH_UNIT  = 3'd2,
        EU_INT_ALU      = 3'd3,
        EU_NONE         = 3'd4       // straight to the ROB
    } issue_eu_t;

    typedef enum logic [3:0] {
        EXC_ILLEGAL_INSTR = 4'd2,
        EXC_BREAKPOINT    = 4'd3,
        EXC_ECALL_M       = 4'd11
    } except_code_t;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_SHAMT
    } imm_format_t;

    localparam logic [6:0] OPC_LOAD     = 7'b000_0011;
    localparam logic [6:0] OPC_STORE    = 7'b010_0011;
    localparam logic [6:0] OPC_BRANCH   = 7'b110_0011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b001_0011;
    localparam logic [6:0] OPC_OP       = 7'b011_0011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b000_1111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b111_0011;

endpackage
